// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_versat
FILELIST  := tb.f
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))
FAIL_MSG  := TEST FAILED
PASS_MSG  := TEST PASSED

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended early"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/bus_merge.sv ====
`default_nettype none

module bus_merge (
  input  wire                       clk,
  input  wire                       rst,
  input  wire versat_pkg::bus_req_t m_req [versat_pkg::N_MASTERS],
  output versat_pkg::bus_rsp_t      m_rsp [versat_pkg::N_MASTERS],
  output versat_pkg::bus_req_t      s_req,
  input  wire versat_pkg::bus_rsp_t s_rsp
);

  logic                            running;
  logic [versat_pkg::MASTER_W-1:0] owner;
  logic [versat_pkg::MASTER_W-1:0] rr_ptr;
  logic [versat_pkg::MASTER_W-1:0] pick;
  logic                            pick_valid;
  logic                            burst_end;

  // First requester at or after rr_ptr, wrapping
  always_comb begin : rr_pick
    int idx;
    pick       = '0;
    pick_valid = 1'b0;
    for (int k = versat_pkg::N_MASTERS - 1; k >= 0; k--) begin
      idx = int'(rr_ptr) + k;
      if (idx >= versat_pkg::N_MASTERS) idx = idx - versat_pkg::N_MASTERS;
      if (m_req[idx].valid) begin
        pick       = idx[versat_pkg::MASTER_W-1:0];
        pick_valid = 1'b1;
      end
    end
  end

  assign burst_end = running && s_req.valid && s_rsp.ready && s_rsp.last;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      running <= 1'b0;
      owner   <= '0;
      rr_ptr  <= '0;
    end else if (!running) begin
      if (pick_valid) begin
        running <= 1'b1;
        owner   <= pick;
        rr_ptr  <= (pick == versat_pkg::N_MASTERS - 1) ? '0 : pick + 1'b1;
      end
    end else if (burst_end) begin
      running <= 1'b0;   // Bus idle for one cycle before the next grant
    end
  end

  always_comb begin
    s_req = '0;
    if (running) s_req = m_req[owner];
    for (int i = 0; i < versat_pkg::N_MASTERS; i++) begin
      m_rsp[i] = '0;
      if (running && owner == i) m_rsp[i] = s_rsp;   // Owner only
    end
  end

endmodule

`default_nettype wire

// ==== design/copy_unit.sv ====
`default_nettype none

module copy_unit (
  input  wire                        clk,
  input  wire                        rst,
  input  wire versat_pkg::copy_cfg_t cfg,
  output versat_pkg::copy_stat_t     stat,
  output versat_pkg::bus_req_t       req,
  input  wire versat_pkg::bus_rsp_t  rsp
);

  typedef enum logic [1:0] {CU_IDLE, CU_READ, CU_WRITE} cu_state_t;

  cu_state_t                         state;
  logic [versat_pkg::MEM_ADDR_W-1:0] src_q;
  logic [versat_pkg::MEM_ADDR_W-1:0] dst_q;
  logic [versat_pkg::LEN_W-1:0]      len_q;
  logic [versat_pkg::LEN_W-1:0]      idx;
  logic                              gap_q;
  logic                              done_q;
  logic                              beat;
  logic                              accept;
  logic [versat_pkg::DATA_W-1:0]     buffer [versat_pkg::BUF_WORDS];

  assign beat   = req.valid && rsp.ready;
  assign accept = state == CU_IDLE && cfg.start;   // Start is dropped while busy

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state  <= CU_IDLE;
      idx    <= '0;
      gap_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      case (state)
        CU_IDLE: begin
          if (accept) begin
            state  <= CU_READ;
            done_q <= 1'b0;
          end
        end
        CU_READ: begin
          if (beat) begin
            idx <= rsp.last ? '0 : idx + 1'b1;
            if (rsp.last) begin
              state <= CU_WRITE;
              gap_q <= 1'b1;   // Drop valid for a cycle between bursts
            end
          end
        end
        CU_WRITE: begin
          gap_q <= 1'b0;
          if (beat) begin
            idx <= rsp.last ? '0 : idx + 1'b1;
            if (rsp.last) begin
              state  <= CU_IDLE;
              done_q <= 1'b1;
            end
          end
        end
        default: state <= CU_IDLE;
      endcase
    end
  end

  // Configuration is captured so the host may rewrite registers mid-copy
  always_ff @(posedge clk) begin
    if (accept) begin
      src_q <= cfg.src;
      dst_q <= cfg.dst;
      len_q <= cfg.len;
    end
    if (state == CU_READ && beat) buffer[idx] <= rsp.rdata;
  end

  always_comb begin
    req.valid = state != CU_IDLE && !gap_q;
    req.addr  = (state == CU_WRITE) ? dst_q : src_q;
    req.wdata = buffer[idx];
    req.wstrb = (state == CU_WRITE) ? '1 : '0;
    req.len   = len_q;
  end

  assign stat.busy = state != CU_IDLE;
  assign stat.done = done_q;

endmodule

`default_nettype wire

// ==== design/mem_port.sv ====
`default_nettype none

module mem_port (
  input  wire                       clk,
  input  wire                       rst,
  input  wire versat_pkg::bus_req_t req,
  output versat_pkg::bus_rsp_t      rsp
);

  typedef struct packed {
    logic                              last;
    logic [versat_pkg::MEM_ADDR_W-1:0] addr;
  } mem_cmd_t;

  typedef struct packed {
    logic                          last;
    logic [versat_pkg::DATA_W-1:0] data;
  } rd_beat_t;

  logic [versat_pkg::DATA_W-1:0]     mem [versat_pkg::MEM_WORDS];
  logic [versat_pkg::LEN_W-1:0]      beat_cnt;
  logic [versat_pkg::MEM_ADDR_W-1:0] beat_addr;
  logic                              cmd_done;
  logic                              wr_beat;
  logic                              cmd_in_valid;
  logic                              cmd_in_ready;
  logic                              cmd_push;
  logic                              cmd_valid;
  mem_cmd_t                          cmd_in;
  mem_cmd_t                          cmd_out;
  rd_beat_t                          rd_in;
  rd_beat_t                          rd_out;
  logic                              rd_in_ready;
  logic                              rd_valid;
  logic                              rd_end;

  // Wraps at the top of memory
  assign beat_addr    = req.addr +
                        {{(versat_pkg::MEM_ADDR_W - versat_pkg::LEN_W){1'b0}}, beat_cnt};
  assign wr_beat      = req.valid && versat_pkg::is_write(req);
  assign cmd_in_valid = req.valid && !versat_pkg::is_write(req) && !cmd_done;
  assign cmd_push     = cmd_in_valid && cmd_in_ready;
  assign rd_end       = rd_valid && rd_out.last && req.valid;

  always_comb begin
    cmd_in.last = beat_cnt == req.len;
    cmd_in.addr = beat_addr;
    rd_in.last  = cmd_out.last;
    rd_in.data  = mem[cmd_out.addr];   // Registered by the data buffer
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      beat_cnt <= '0;
      cmd_done <= 1'b0;
    end else begin
      if (wr_beat || cmd_push) beat_cnt <= (beat_cnt == req.len) ? '0 : beat_cnt + 1'b1;
      if (cmd_push && cmd_in.last) cmd_done <= 1'b1;
      else if (rd_end) cmd_done <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    for (int b = 0; b < versat_pkg::STRB_W; b++) begin
      if (wr_beat && req.wstrb[b]) mem[beat_addr][8*b +: 8] <= req.wdata[8*b +: 8];
    end
  end

  skid_buffer #(.T(mem_cmd_t)) i_cmd_buf (
    .clk      (clk),
    .rst      (rst),
    .in_valid (cmd_in_valid),
    .in_ready (cmd_in_ready),
    .in_data  (cmd_in),
    .out_valid(cmd_valid),
    .out_ready(rd_in_ready),
    .out_data (cmd_out)
  );

  skid_buffer #(.T(rd_beat_t)) i_rd_buf (
    .clk      (clk),
    .rst      (rst),
    .in_valid (cmd_valid),
    .in_ready (rd_in_ready),
    .in_data  (rd_in),
    .out_valid(rd_valid),
    .out_ready(req.valid),
    .out_data (rd_out)
  );

  always_comb begin
    if (versat_pkg::is_write(req)) begin
      rsp.ready = wr_beat;
      rsp.last  = wr_beat && beat_cnt == req.len;
    end else begin
      rsp.ready = rd_valid;
      rsp.last  = rd_valid && rd_out.last;
    end
    rsp.rdata = rd_out.data;
  end

endmodule

`default_nettype wire

// ==== design/skid_buffer.sv ====
`default_nettype none

module skid_buffer #(
  parameter type T = logic
) (
  input  wire   clk,
  input  wire   rst,
  input  wire   in_valid,
  output logic  in_ready,
  input  wire T in_data,
  output logic  out_valid,
  input  wire   out_ready,
  output T      out_data
);

  T     main_q;
  T     stored_q;
  logic has_stored;
  logic main_free;
  logic load_main;
  logic store_data;

  assign main_free  = !out_valid || out_ready;
  assign load_main  = main_free && (has_stored || in_valid);
  assign store_data = !main_free && in_valid && in_ready;
  assign in_ready   = !has_stored;   // From a flop, no path from out_ready
  assign out_data   = main_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_valid  <= 1'b0;
      has_stored <= 1'b0;
    end else if (main_free) begin
      out_valid  <= has_stored || in_valid;
      has_stored <= 1'b0;
    end else if (store_data) begin
      has_stored <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load_main) main_q <= has_stored ? stored_q : in_data;
    if (store_data) stored_q <= in_data;   // Spare slot while output stalls
  end

endmodule

`default_nettype wire

// ==== design/versat_pkg.sv ====
`default_nettype none

package versat_pkg;

  localparam int DATA_W     = 32;
  localparam int STRB_W     = DATA_W / 8;
  localparam int MEM_ADDR_W = 8;
  localparam int MEM_WORDS  = 1 << MEM_ADDR_W;
  localparam int LEN_W      = 4;              // Words minus one
  localparam int BUF_WORDS  = 1 << LEN_W;
  localparam int N_UNITS    = 2;
  localparam int N_MASTERS  = N_UNITS + 1;    // Host window is the last master
  localparam int MASTER_W   = $clog2(N_MASTERS);
  localparam int WB_ADR_W   = 12;

  // Byte offsets inside a unit's 16-byte block
  localparam logic [3:0] REG_SRC  = 4'h0;
  localparam logic [3:0] REG_DST  = 4'h4;
  localparam logic [3:0] REG_LEN  = 4'h8;
  localparam logic [3:0] REG_CTRL = 4'hC;

  localparam logic [WB_ADR_W-1:0] MEM_BASE = 12'h400;

  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [WB_ADR_W-1:0] adr;
    logic [DATA_W-1:0]   dat_w;
    logic [STRB_W-1:0]   sel;
  } wb_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] dat_r;
    logic              ack;
  } wb_rsp_t;

  typedef struct packed {
    logic                  valid;
    logic [MEM_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]     wdata;
    logic [STRB_W-1:0]     wstrb;
    logic [LEN_W-1:0]      len;
  } bus_req_t;

  typedef struct packed {
    logic              ready;
    logic              last;
    logic [DATA_W-1:0] rdata;
  } bus_rsp_t;

  typedef struct packed {
    logic [MEM_ADDR_W-1:0] src;
    logic [MEM_ADDR_W-1:0] dst;
    logic [LEN_W-1:0]      len;
    logic                  start;
  } copy_cfg_t;

  typedef struct packed {
    logic busy;
    logic done;
  } copy_stat_t;

  // Any strobe bit set means a write burst
  function automatic logic is_write(bus_req_t r);
    return |r.wstrb;
  endfunction

endpackage

`default_nettype wire

// ==== design/versat_subsys.sv ====
`default_nettype none

module versat_subsys (
  input  wire                      clk,
  input  wire                      rst,
  input  wire versat_pkg::wb_req_t wb_in,
  output versat_pkg::wb_rsp_t      wb_out
);

  versat_pkg::copy_cfg_t  cfg   [versat_pkg::N_UNITS];
  versat_pkg::copy_stat_t stat  [versat_pkg::N_UNITS];
  versat_pkg::bus_req_t   m_req [versat_pkg::N_MASTERS];
  versat_pkg::bus_rsp_t   m_rsp [versat_pkg::N_MASTERS];
  versat_pkg::bus_req_t   s_req;
  versat_pkg::bus_rsp_t   s_rsp;

  wb_regs i_regs (
    .clk     (clk),
    .rst     (rst),
    .wb_in   (wb_in),
    .wb_out  (wb_out),
    .cfg     (cfg),
    .stat    (stat),
    .host_req(m_req[versat_pkg::N_UNITS]),
    .host_rsp(m_rsp[versat_pkg::N_UNITS])
  );

  for (genvar u = 0; u < versat_pkg::N_UNITS; u++) begin : g_unit
    copy_unit i_unit (
      .clk (clk),
      .rst (rst),
      .cfg (cfg[u]),
      .stat(stat[u]),
      .req (m_req[u]),
      .rsp (m_rsp[u])
    );
  end

  bus_merge i_merge (
    .clk  (clk),
    .rst  (rst),
    .m_req(m_req),
    .m_rsp(m_rsp),
    .s_req(s_req),
    .s_rsp(s_rsp)
  );

  mem_port i_mem (
    .clk(clk),
    .rst(rst),
    .req(s_req),
    .rsp(s_rsp)
  );

endmodule

`default_nettype wire

// ==== design/wb_regs.sv ====
`default_nettype none

module wb_regs (
  input  wire                         clk,
  input  wire                         rst,
  input  wire versat_pkg::wb_req_t    wb_in,
  output versat_pkg::wb_rsp_t         wb_out,
  output versat_pkg::copy_cfg_t       cfg [versat_pkg::N_UNITS],
  input  wire versat_pkg::copy_stat_t stat [versat_pkg::N_UNITS],
  output versat_pkg::bus_req_t        host_req,
  input  wire versat_pkg::bus_rsp_t   host_rsp
);

  typedef enum logic [1:0] {WB_IDLE, WB_REG, WB_MEM, WB_DONE} wb_state_t;

  wb_state_t                             state;
  logic [versat_pkg::MEM_ADDR_W-1:0]     src_q [versat_pkg::N_UNITS];
  logic [versat_pkg::MEM_ADDR_W-1:0]     dst_q [versat_pkg::N_UNITS];
  logic [versat_pkg::LEN_W-1:0]          len_q [versat_pkg::N_UNITS];
  logic [versat_pkg::N_UNITS-1:0]        start_q;
  logic                                  host_v;
  logic                                  ack_q;
  logic [versat_pkg::DATA_W-1:0]         dat_q;
  logic [versat_pkg::DATA_W-1:0]         reg_rdata;
  logic [versat_pkg::WB_ADR_W-1:0]       mem_off;
  logic [versat_pkg::WB_ADR_W-5:0]       unit_sel;
  logic [3:0]                            reg_off;
  logic                                  access;
  logic                                  is_mem;
  logic                                  host_end;

  assign access   = wb_in.cyc && wb_in.stb;
  assign is_mem   = wb_in.adr >= versat_pkg::MEM_BASE;
  assign mem_off  = wb_in.adr - versat_pkg::MEM_BASE;
  assign unit_sel = wb_in.adr[versat_pkg::WB_ADR_W-1:4];
  assign reg_off  = wb_in.adr[3:0];
  assign host_end = host_rsp.ready && host_rsp.last;

  // Unmapped offsets and units read as zero
  always_comb begin
    reg_rdata = '0;
    for (int u = 0; u < versat_pkg::N_UNITS; u++) begin
      if (unit_sel == u) begin
        case (reg_off)
          versat_pkg::REG_SRC:  reg_rdata[versat_pkg::MEM_ADDR_W-1:0] = src_q[u];
          versat_pkg::REG_DST:  reg_rdata[versat_pkg::MEM_ADDR_W-1:0] = dst_q[u];
          versat_pkg::REG_LEN:  reg_rdata[versat_pkg::LEN_W-1:0] = len_q[u];
          versat_pkg::REG_CTRL: reg_rdata[1:0] = {stat[u].done, stat[u].busy};
          default:              reg_rdata = '0;
        endcase
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= WB_IDLE;
      ack_q   <= 1'b0;
      host_v  <= 1'b0;
      start_q <= '0;
      src_q   <= '{default: '0};
      dst_q   <= '{default: '0};
      len_q   <= '{default: '0};
    end else begin
      ack_q   <= 1'b0;
      start_q <= '0;
      case (state)
        WB_IDLE: begin
          if (access && is_mem) begin
            host_v <= 1'b1;
            state  <= WB_MEM;
          end else if (access) begin
            state <= WB_REG;
          end
        end
        WB_REG: begin
          ack_q <= 1'b1;
          state <= WB_DONE;
          for (int u = 0; u < versat_pkg::N_UNITS; u++) begin
            if (wb_in.we && unit_sel == u) begin
              case (reg_off)
                versat_pkg::REG_SRC: src_q[u] <= wb_in.dat_w[versat_pkg::MEM_ADDR_W-1:0];
                versat_pkg::REG_DST: dst_q[u] <= wb_in.dat_w[versat_pkg::MEM_ADDR_W-1:0];
                versat_pkg::REG_LEN: len_q[u] <= wb_in.dat_w[versat_pkg::LEN_W-1:0];
                default: ;
              endcase
            end
          end
        end
        WB_MEM: begin
          if (host_end) begin
            host_v <= 1'b0;
            ack_q  <= 1'b1;
            state  <= WB_DONE;
          end
        end
        default: begin
          state <= WB_IDLE;
          // Start fires the cycle after the CTRL ack
          for (int u = 0; u < versat_pkg::N_UNITS; u++) begin
            start_q[u] <= wb_in.we && unit_sel == u && reg_off == versat_pkg::REG_CTRL &&
                          wb_in.dat_w[0];
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == WB_REG) dat_q <= reg_rdata;
    else if (state == WB_MEM && host_end) dat_q <= host_rsp.rdata;
  end

  always_comb begin
    host_req.valid = host_v;
    host_req.addr  = mem_off[versat_pkg::MEM_ADDR_W+1:2];   // Byte to word
    host_req.wdata = wb_in.dat_w;
    host_req.wstrb = wb_in.we ? wb_in.sel : '0;
    host_req.len   = '0;                                    // Single beat
  end

  always_comb begin
    for (int u = 0; u < versat_pkg::N_UNITS; u++) begin
      cfg[u].src   = src_q[u];
      cfg[u].dst   = dst_q[u];
      cfg[u].len   = len_q[u];
      cfg[u].start = start_q[u];
    end
  end

  assign wb_out.dat_r = dat_q;
  assign wb_out.ack   = ack_q;

endmodule

`default_nettype wire

// ==== tb.f ====
design/versat_pkg.sv
design/skid_buffer.sv
design/wb_regs.sv
design/copy_unit.sv
design/bus_merge.sv
design/mem_port.sv
design/versat_subsys.sv
tb/tb_clk_gen.sv
tb/versat_chk.sv
tb/tb_versat.sv

// ==== tb/tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD = 20;   // 40 ns clock
  localparam int RST_CYCLES  = 3;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== tb/tb_versat.sv ====
`default_nettype none

module tb_versat;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          TIMEOUT = 200;   // Cycles per wait
  localparam logic [31:0] SEED    = 32'h19d0_0459;
  localparam int          WORDS   = versat_pkg::MEM_WORDS;

  typedef logic [versat_pkg::WB_ADR_W-1:0] wb_adr_t;
  typedef logic [versat_pkg::DATA_W-1:0]   word_t;
  typedef logic [versat_pkg::STRB_W-1:0]   sel_t;

  logic                clk;
  logic                rst;
  versat_pkg::wb_req_t wb_in;
  versat_pkg::wb_rsp_t wb_out;
  word_t               ref_mem [WORDS];   // Expected memory contents
  int                  errors;
  int                  checks;
  int                  tests;
  int                  cycle_cnt = 0;

  tb_clk_gen i_clk_gen (.clk(clk), .rst(rst));

  versat_subsys i_dut (.clk(clk), .rst(rst), .wb_in(wb_in), .wb_out(wb_out));

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  function automatic int wrap(input int w);
    return w % WORDS;
  endfunction

  function automatic wb_adr_t reg_addr(input int unit, input logic [3:0] off);
    return wb_adr_t'(unit * 16 + int'(off));
  endfunction

  function automatic wb_adr_t mem_addr(input int word);
    return wb_adr_t'(int'(versat_pkg::MEM_BASE) + wrap(word) * 4);
  endfunction

  function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input sel_t sel);
    word_t m;
    m = old_w;
    for (int b = 0; b < versat_pkg::STRB_W; b++) begin
      if (sel[b]) m[8*b +: 8] = new_w[8*b +: 8];
    end
    return m;
  endfunction

  task automatic check_eq(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Ack is sampled on the falling edge, the request drops on the next rising edge
  task automatic wb_cycle(input logic we, input wb_adr_t adr, input word_t data,
                          input sel_t sel, output word_t rdata);
    versat_pkg::wb_req_t r;
    int n;
    r       = '0;
    r.cyc   = 1'b1;
    r.stb   = 1'b1;
    r.we    = we;
    r.adr   = adr;
    r.dat_w = data;
    r.sel   = sel;
    n       = 0;
    @(posedge clk);
    wb_in <= r;
    do begin
      @(negedge clk);
      n++;
    end while (!wb_out.ack && n < TIMEOUT);
    if (!wb_out.ack) begin
      $display("No Wishbone ack for address 0x%03h within %0d cycles", adr, TIMEOUT);
      errors++;
    end
    rdata = wb_out.dat_r;
    @(posedge clk);
    wb_in <= '0;
  endtask

  task automatic wb_write(input wb_adr_t adr, input word_t data, input sel_t sel);
    word_t unused;
    wb_cycle(1'b1, adr, data, sel, unused);
  endtask

  task automatic wb_read(input wb_adr_t adr, output word_t data);
    wb_cycle(1'b0, adr, '0, '1, data);
  endtask

  task automatic write_mem(input int word, input word_t data, input sel_t sel);
    wb_write(mem_addr(word), data, sel);
    ref_mem[wrap(word)] = merge_bytes(ref_mem[wrap(word)], data, sel);
  endtask

  task automatic fill_region(input int base, input int count);
    for (int i = 0; i < count; i++) write_mem(base + i, $urandom(), '1);
  endtask

  task automatic check_region(input int base, input int count);
    word_t rd;
    for (int i = 0; i < count; i++) begin
      wb_read(mem_addr(base + i), rd);
      check_eq($sformatf("mem[0x%02h]", wrap(base + i)), rd, ref_mem[wrap(base + i)]);
    end
  endtask

  task automatic config_unit(input int unit, input int src, input int dst, input int len);
    wb_write(reg_addr(unit, versat_pkg::REG_SRC), src, '1);
    wb_write(reg_addr(unit, versat_pkg::REG_DST), dst, '1);
    wb_write(reg_addr(unit, versat_pkg::REG_LEN), len, '1);
  endtask

  task automatic start_unit(input int unit);
    wb_write(reg_addr(unit, versat_pkg::REG_CTRL), 32'h1, '1);
  endtask

  task automatic wait_done(input int unit);
    word_t ctrl;
    int t0;
    t0   = cycle_cnt;
    ctrl = '0;
    while (!ctrl[1] && cycle_cnt - t0 < TIMEOUT) begin
      wb_read(reg_addr(unit, versat_pkg::REG_CTRL), ctrl);
    end
    if (!ctrl[1]) begin
      $display("Unit %0d did not report done within %0d cycles", unit, TIMEOUT);
      errors++;
    end else begin
      check_eq($sformatf("unit%0d ctrl", unit), ctrl, 32'h2);   // Done set, busy clear
    end
  endtask

  // Model of one copy, len is words minus one
  task automatic expect_copy(input int src, input int dst, input int len);
    word_t tmp [versat_pkg::BUF_WORDS];
    for (int i = 0; i <= len; i++) tmp[i] = ref_mem[wrap(src + i)];
    for (int i = 0; i <= len; i++) ref_mem[wrap(dst + i)] = tmp[i];
  endtask

  task automatic report(input string name, input int errs_before);
    tests++;
    $display("%-20s %0d error(s)", name, errors - errs_before);
  endtask

  task automatic test_registers();
    int    e0;
    word_t rd;
    word_t v [3];
    e0 = errors;
    for (int u = 0; u < versat_pkg::N_UNITS; u++) begin
      wb_read(reg_addr(u, versat_pkg::REG_CTRL), rd);
      check_eq($sformatf("unit%0d ctrl", u), rd, 32'h0);
      v[0] = $urandom_range(WORDS - 1, 0);
      v[1] = $urandom_range(WORDS - 1, 0);
      v[2] = $urandom();
      config_unit(u, v[0], v[1], v[2]);
      wb_read(reg_addr(u, versat_pkg::REG_SRC), rd);
      check_eq($sformatf("unit%0d src", u), rd, v[0]);
      wb_read(reg_addr(u, versat_pkg::REG_DST), rd);
      check_eq($sformatf("unit%0d dst", u), rd, v[1]);
      wb_read(reg_addr(u, versat_pkg::REG_LEN), rd);
      check_eq($sformatf("unit%0d len", u), rd, v[2] & ((1 << versat_pkg::LEN_W) - 1));
    end
    wb_read(reg_addr(versat_pkg::N_UNITS, versat_pkg::REG_SRC), rd);
    check_eq("unmapped register", rd, 32'h0);
    report("registers", e0);
  endtask

  task automatic test_mem_window();
    int e0;
    e0 = errors;
    fill_region(8'h10, 8);
    write_mem(8'h12, $urandom(), 4'h3);
    write_mem(8'h15, $urandom(), 4'hC);
    write_mem(8'h17, $urandom(), 4'h3);
    check_region(8'h10, 8);
    report("memory window", e0);
  endtask

  task automatic test_single_copy();
    int e0;
    e0 = errors;
    fill_region(8'h20, 16);
    config_unit(0, 8'h20, 8'h40, 15);
    start_unit(0);
    wait_done(0);
    expect_copy(8'h20, 8'h40, 15);
    check_region(8'h40, 16);
    check_region(8'h20, 16);   // Source untouched
    report("single copy", e0);
  endtask

  task automatic test_concurrent();
    int e0;
    e0 = errors;
    fill_region(8'h60, 12);
    fill_region(8'h70, 1);
    config_unit(0, 8'h60, 8'h80, 11);
    config_unit(1, 8'h70, 8'h90, 0);   // Single word
    start_unit(0);
    start_unit(1);
    wait_done(0);
    wait_done(1);
    expect_copy(8'h60, 8'h80, 11);
    expect_copy(8'h70, 8'h90, 0);
    check_region(8'h80, 12);
    check_region(8'h90, 1);
    report("concurrent copies", e0);
  endtask

  task automatic test_host_while_busy();
    int    e0;
    word_t rd;
    e0 = errors;
    fill_region(8'hF8, 16);   // Wraps past the top of memory
    config_unit(1, 8'hF8, 8'hA0, 15);
    start_unit(1);
    wb_read(reg_addr(1, versat_pkg::REG_CTRL), rd);
    check_eq("unit1 ctrl.busy", {31'b0, rd[0]}, 32'h1);
    fill_region(8'hC0, 4);
    check_region(8'hC0, 4);
    wait_done(1);
    expect_copy(8'hF8, 8'hA0, 15);
    check_region(8'hA0, 16);
    report("host while busy", e0);
  endtask

  task automatic test_start_while_busy();
    int    e0;
    word_t rd;
    e0 = errors;
    fill_region(8'hD0, 16);
    fill_region(8'h50, 8);
    config_unit(0, 8'hD0, 8'hE0, 15);
    start_unit(0);
    wb_write(reg_addr(0, versat_pkg::REG_DST), 32'h50, '1);
    wb_write(reg_addr(0, versat_pkg::REG_LEN), 32'h7, '1);
    wb_read(reg_addr(0, versat_pkg::REG_CTRL), rd);
    check_eq("unit0 ctrl.busy", {31'b0, rd[0]}, 32'h1);
    start_unit(0);   // Must be ignored
    wait_done(0);
    expect_copy(8'hD0, 8'hE0, 15);
    check_region(8'hE0, 16);
    check_region(8'h50, 8);
    report("start while busy", e0);
  endtask

  initial begin
    int n;
    wb_in  = '0;
    errors = 0;
    checks = 0;
    tests  = 0;
    void'($urandom(SEED));
    for (n = 0; n < TIMEOUT && rst !== 1'b0; n++) @(posedge clk);
    if (rst !== 1'b0) begin
      $display("Reset was not released within %0d cycles", TIMEOUT);
      errors++;
    end
    test_registers();
    test_mem_window();
    test_single_copy();
    test_concurrent();
    test_host_while_busy();
    test_start_while_busy();
    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/versat_chk.sv ====
`default_nettype none

module versat_chk (
  input wire                       clk,
  input wire                       rst,
  input wire versat_pkg::wb_req_t  wb_in,
  input wire versat_pkg::wb_rsp_t  wb_out,
  input wire versat_pkg::bus_req_t s_req,
  input wire versat_pkg::bus_rsp_t s_rsp,
  input wire versat_pkg::bus_rsp_t m_rsp [versat_pkg::N_MASTERS]
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [versat_pkg::N_MASTERS-1:0] ready_vec;
  logic                             in_burst;

  always_comb begin
    for (int i = 0; i < versat_pkg::N_MASTERS; i++) begin
      ready_vec[i] = m_rsp[i].ready;
    end
  end

  // Burst still open after this cycle
  assign in_burst = s_req.valid && !(s_rsp.ready && s_rsp.last);

  a_ready_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(ready_vec))
    else $error("ready routed to more than one master");

  a_burst_stable: assert property (@(posedge clk) disable iff (rst)
    in_burst |=> s_req.valid && $stable(s_req.addr) && $stable(s_req.len))
    else $error("forwarded addr or len changed inside a burst");

  a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
    wb_out.ack |-> wb_in.cyc && wb_in.stb)
    else $error("Wishbone ack without cyc and stb");

endmodule

// The top level holds both the arbiter ports and the Wishbone port
bind versat_subsys versat_chk i_chk (
  .clk   (clk),
  .rst   (rst),
  .wb_in (wb_in),
  .wb_out(wb_out),
  .s_req (s_req),
  .s_rsp (s_rsp),
  .m_rsp (m_rsp)
);

`default_nettype wire
